// ==== source/fdiv_consts.svh ====
// Constants for the binary32 floating-point divider
// Format field widths, exponent bias, divider iteration count and latency
`ifndef FDIV_CONSTS_SVH
`define FDIV_CONSTS_SVH

`define FDIV_EXP_W 8                // Biased exponent field
`define FDIV_FRAC_W 23              // Stored fraction field
`define FDIV_MANT_W 24              // Significand including the hidden one

`define FDIV_BIAS 127               // Exponent bias of binary32

// Three quotient bits retire per cycle, 48 bits in total
`define FDIV_ITER 16

`define FDIV_LATENCY 18             // Start edge to done strobe, in clocks

`define FDIV_QNAN 32'h7FC0_0000     // Canonical quiet NaN, payload not kept

`endif

// ==== source/fdivPkg.sv ====
// Shared types of the floating-point divider
// Packed word, working exponent, significand, quotient, flags and FSM states
`include "fdiv_consts.svh"

package fdivPkg;

	typedef logic [`FDIV_EXP_W+`FDIV_FRAC_W:0] float_t;   // Sign, exponent, fraction
	typedef logic signed [`FDIV_EXP_W+1:0] exp_t;       // Two guard bits for range checks
	typedef logic [`FDIV_MANT_W-1:0] mant_t;             // Hidden bit on top
	typedef logic [2*`FDIV_MANT_W-1:0] quot_t;           // Raw divider output

	// Flag order from the top bit: invalid, divByZero, overflow, underflow, inexact
	typedef logic [4:0] flags_t;

	typedef enum logic [1:0] {
		scNormal,                                        // Result comes from the datapath
		scZero,                                          // Signed zero
		scInf,                                           // Signed infinity
		scNaN                                            // Canonical quiet NaN
	} specClass_t;

	typedef enum logic [1:0] {
		dsIdle,                                          // Waiting for start
		dsRun,                                           // Iterating
		dsDone                                           // Remainder check and done strobe
	} divState_t;

endpackage

// ==== source/mantDivR8.sv ====
// Radix-8 non-restoring significand divider
// Retires three quotient bits per clock over 16 cycles and reports
// the full 48-bit quotient plus whether the final remainder is nonzero
`timescale 1ns/1ps
`include "fdiv_consts.svh"

module mantDivR8 (
	input  logic clk,
	input  logic arstN,
	input  logic start,
	input  fdivPkg::mant_t divd,
	input  fdivPkg::mant_t dvsr,
	output fdivPkg::quot_t quot,
	output logic remNz,
	output logic mantDone,
	output logic busy
);
	// Partial remainder needs a sign bit and one bit of headroom for 2r
	typedef logic [`FDIV_MANT_W+1:0] rem_t;
	typedef logic [$clog2(`FDIV_ITER)-1:0] cnt_t;

	fdivPkg::divState_t state;              // Control FSM
	cnt_t iterCnt;                          // Iterations still to run
	fdivPkg::quot_t qReg;                   // Dividend bits out on top, quotient bits in below
	rem_t rem;                              // Partial remainder, two's complement
	fdivPkg::mant_t dvsrReg;                // Divisor held for the whole operation
	rem_t rem1;
	rem_t rem2;
	rem_t rem3;
	rem_t remFix;                           // Remainder after the final correction

	// One non-restoring step: shift in the next dividend bit, then add or subtract
	function automatic rem_t nrStep(input rem_t r, input logic bitIn, input fdivPkg::mant_t d);
		rem_t shifted;
		rem_t dExt;
		shifted = {r[`FDIV_MANT_W:0], bitIn};        // Top bit always equals the sign, so 2r fits
		dExt = rem_t'(d);
		nrStep = r[$high(r)] ? shifted + dExt : shifted - dExt;
	endfunction

	assign rem1 = nrStep(rem, qReg[$high(qReg)], dvsrReg);       // First step of the cycle
	assign rem2 = nrStep(rem1, qReg[$high(qReg)-1], dvsrReg);
	assign rem3 = nrStep(rem2, qReg[$high(qReg)-2], dvsrReg);    // Third step, stored back

	// A negative final remainder is short by one divisor
	assign remFix = rem[$high(rem)] ? rem + rem_t'(dvsrReg) : rem;

	assign quot = qReg;
	assign busy = (state != fdivPkg::dsIdle);   // Drops in the cycle mantDone is high

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state    <= fdivPkg::dsIdle;
			iterCnt  <= '0;
			mantDone <= 1'b0;
		end else begin
			mantDone <= 1'b0;                       // Strobe lasts one cycle
			unique case (state)
				fdivPkg::dsIdle: begin
					if (start) begin                    // A start while busy never reaches here
						state   <= fdivPkg::dsRun;
						iterCnt <= cnt_t'(`FDIV_ITER - 1);
					end
				end
				fdivPkg::dsRun: begin
					if (iterCnt == '0)
						state <= fdivPkg::dsDone;       // Last step retired on this edge
					else
						iterCnt <= iterCnt - 1'b1;
				end
				fdivPkg::dsDone: begin
					state    <= fdivPkg::dsIdle;
					mantDone <= 1'b1;                   // 17 edges after the start edge
				end
				default: state <= fdivPkg::dsIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == fdivPkg::dsIdle && start) begin
			qReg    <= {divd, {`FDIV_MANT_W{1'b0}}};  // Dividend on top, zeros extend the quotient
			rem     <= '0;
			dvsrReg <= dvsr;
		end else if (state == fdivPkg::dsRun) begin
			// Quotient bits are the inverted remainder signs, oldest step highest
			qReg <= {qReg[$high(qReg)-3:0], ~rem1[$high(rem1)], ~rem2[$high(rem2)],
				~rem3[$high(rem3)]};
			rem  <= rem3;
		end
		if (state == fdivPkg::dsDone)
			remNz <= |remFix;                       // Only sticky information leaves the block
	end

endmodule

// ==== source/expSpecial.sv ====
// Exponent and special-case unit of the floating-point divider
// Classifies both operands, decides the special result class and
// holds the sign and biased exponent difference until the next start
`timescale 1ns/1ps
`include "fdiv_consts.svh"

module expSpecial (
	input  logic clk,
	input  logic arstN,
	input  logic start,
	input  fdivPkg::float_t a,
	input  fdivPkg::float_t b,
	output logic resSign,
	output fdivPkg::exp_t resExp,
	output fdivPkg::specClass_t specClass,
	output fdivPkg::flags_t specFlags
);
	logic [`FDIV_EXP_W-1:0] aExp;
	logic [`FDIV_EXP_W-1:0] bExp;
	logic [`FDIV_FRAC_W-1:0] aFrac;
	logic [`FDIV_FRAC_W-1:0] bFrac;
	logic aZero;
	logic bZero;
	logic aInf;
	logic bInf;
	logic aNaN;
	logic bNaN;
	fdivPkg::specClass_t decClass;        // Class picked for this operand pair
	logic decInvalid;
	logic decDivZero;
	fdivPkg::exp_t expDiff;

	assign aExp  = a[`FDIV_FRAC_W +: `FDIV_EXP_W];
	assign bExp  = b[`FDIV_FRAC_W +: `FDIV_EXP_W];
	assign aFrac = a[`FDIV_FRAC_W-1:0];
	assign bFrac = b[`FDIV_FRAC_W-1:0];

	// Subnormals have a zero exponent field and count as zero
	assign aZero = (aExp == '0);
	assign bZero = (bExp == '0);
	assign aInf  = (aExp == '1) && (aFrac == '0);
	assign bInf  = (bExp == '1) && (bFrac == '0);
	assign aNaN  = (aExp == '1) && (aFrac != '0);
	assign bNaN  = (bExp == '1) && (bFrac != '0);

	// Unnormalized result exponent, the normalize stage may still take one off
	assign expDiff = fdivPkg::exp_t'({2'b00, aExp}) - fdivPkg::exp_t'({2'b00, bExp})
		+ fdivPkg::exp_t'(`FDIV_BIAS);

	always_comb begin
		decClass   = fdivPkg::scNormal;
		decInvalid = 1'b0;
		decDivZero = 1'b0;
		if (aNaN || bNaN || (aZero && bZero) || (aInf && bInf)) begin
			decClass   = fdivPkg::scNaN;          // Any NaN in, 0/0 and inf/inf
			decInvalid = 1'b1;
		end else if (aInf) begin
			decClass = fdivPkg::scInf;            // inf over finite, zero divisor included
		end else if (bZero) begin
			decClass   = fdivPkg::scInf;          // Finite nonzero over zero
			decDivZero = 1'b1;
		end else if (bInf || aZero) begin
			decClass = fdivPkg::scZero;           // Finite over inf, or zero over nonzero
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			specClass <= fdivPkg::scNormal;
			specFlags <= '0;
		end else if (start) begin
			specClass <= decClass;
			specFlags <= {decInvalid, decDivZero, 3'b000};   // Range and inexact flags come later
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			resSign <= a[$high(a)] ^ b[$high(b)];   // Also used for signed zero and inf
			resExp  <= expDiff;
		end
	end

endmodule

// ==== source/normPack.sv ====
// Normalize-and-pack stage of the floating-point divider
// Normalizes the raw quotient by one place, truncates toward zero,
// checks the exponent range and registers the packed word and flags
`timescale 1ns/1ps
`include "fdiv_consts.svh"

module normPack (
	input  logic clk,
	input  logic arstN,
	input  logic mantDone,
	input  fdivPkg::quot_t quot,
	input  logic remNz,
	input  logic resSign,
	input  fdivPkg::exp_t resExp,
	input  fdivPkg::specClass_t specClass,
	input  fdivPkg::flags_t specFlags,
	output fdivPkg::float_t result,
	output fdivPkg::flags_t flags,
	output logic done
);
	logic hiBit;                                // Quotient is 1.x rather than 0.1x
	fdivPkg::exp_t normExp;
	logic [`FDIV_FRAC_W-1:0] frac;
	logic inexact;
	logic expOvf;
	logic expUnf;
	fdivPkg::float_t packWord;
	fdivPkg::flags_t packFlags;

	// Significand ratio lies in (0.5, 2), so the leading one sits at bit 24 or 23
	assign hiBit   = quot[`FDIV_MANT_W];
	assign normExp = hiBit ? resExp : resExp - fdivPkg::exp_t'(1);
	assign frac    = hiBit ? quot[`FDIV_MANT_W-1:1] : quot[`FDIV_FRAC_W-1:0];

	// Only the 1.x case drops a quotient bit, the remainder covers the rest
	assign inexact = (hiBit & quot[0]) | remNz;

	assign expOvf = (normExp >= fdivPkg::exp_t'((1 << `FDIV_EXP_W) - 1));
	assign expUnf = (normExp <= fdivPkg::exp_t'(0));

	always_comb begin
		unique case (specClass)
			fdivPkg::scNaN: begin
				packWord  = `FDIV_QNAN;
				packFlags = specFlags;
			end
			fdivPkg::scInf: begin
				packWord  = {resSign, {`FDIV_EXP_W{1'b1}}, {`FDIV_FRAC_W{1'b0}}};
				packFlags = specFlags;                          // divByZero when the divisor was zero
			end
			fdivPkg::scZero: begin
				packWord  = {resSign, {(`FDIV_EXP_W+`FDIV_FRAC_W){1'b0}}};
				packFlags = specFlags;
			end
			default: begin
				if (expOvf) begin
					packWord  = {resSign, {`FDIV_EXP_W{1'b1}}, {`FDIV_FRAC_W{1'b0}}};
					packFlags = 5'b00101;                       // Overflow and inexact
				end else if (expUnf) begin
					packWord  = {resSign, {(`FDIV_EXP_W+`FDIV_FRAC_W){1'b0}}};
					packFlags = 5'b00011;                       // Flushed to zero, underflow and inexact
				end else begin
					packWord  = {resSign, normExp[`FDIV_EXP_W-1:0], frac};
					packFlags = {4'b0000, inexact};
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			result <= '0;
			flags  <= '0;
			done   <= 1'b0;
		end else begin
			done <= mantDone;                   // One clock behind the divider strobe
			if (mantDone) begin
				result <= packWord;             // Held until the next operation finishes
				flags  <= packFlags;
			end
		end
	end

endmodule

// ==== source/fdivTop.sv ====
// Single-precision floating-point divider, top level
// Joins the radix-8 significand divider, the exponent and special-case
// unit and the normalize-and-pack stage behind a start/done handshake
`timescale 1ns/1ps

module fdivTop (
	input  logic clk,
	input  logic arstN,
	input  logic start,
	input  fdivPkg::float_t a,
	input  fdivPkg::float_t b,
	output fdivPkg::float_t result,
	output fdivPkg::flags_t flags,
	output logic done,
	output logic busy
);
	fdivPkg::mant_t aMant;                  // Significands with the hidden one restored
	fdivPkg::mant_t bMant;
	logic startAcc;                         // Start that the divider will take
	fdivPkg::quot_t quot;
	logic remNz;
	logic mantDone;
	logic resSign;
	fdivPkg::exp_t resExp;
	fdivPkg::specClass_t specClass;
	fdivPkg::flags_t specFlags;

	// Zero exponent field means zero or subnormal, both read as zero
	assign aMant = (|a[30:23]) ? {1'b1, a[22:0]} : '0;
	assign bMant = (|b[30:23]) ? {1'b1, b[22:0]} : '0;

	// Keeps the exponent unit on the operation the divider is running
	assign startAcc = start & ~busy;

	mantDivR8 u_mantDiv (
		.clk     (clk),
		.arstN   (arstN),
		.start   (start),
		.divd    (aMant),
		.dvsr    (bMant),
		.quot    (quot),
		.remNz   (remNz),
		.mantDone(mantDone),
		.busy    (busy)
	);

	expSpecial u_expSpecial (
		.clk      (clk),
		.arstN    (arstN),
		.start    (startAcc),
		.a        (a),
		.b        (b),
		.resSign  (resSign),
		.resExp   (resExp),
		.specClass(specClass),
		.specFlags(specFlags)
	);

	normPack u_normPack (
		.clk      (clk),
		.arstN    (arstN),
		.mantDone (mantDone),
		.quot     (quot),
		.remNz    (remNz),
		.resSign  (resSign),
		.resExp   (resExp),
		.specClass(specClass),
		.specFlags(specFlags),
		.result   (result),
		.flags    (flags),
		.done     (done)
	);

endmodule

// ==== testbench/fdivTop_sva.sv ====
// Handshake and flag assertions for the floating-point divider
// Bound to the top level, checks the done strobe timing and NaN flagging
`timescale 1ns/1ps
`include "fdiv_consts.svh"

module fdivTop_sva (
	input logic clk,
	input logic arstN,
	input logic start,
	input logic busy,
	input logic done,
	input fdivPkg::float_t result,
	input fdivPkg::flags_t flags
);
	logic accepted;                             // Start that begins an operation

	assign accepted = start & ~busy;

	doneOneCycle: assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// done changes on the LATENCY-th edge, so it is sampled one edge later
	doneAfterStart: assert property (@(posedge clk) disable iff (!arstN)
		done |-> $past(accepted, `FDIV_LATENCY + 1))
		else $error("done fired without a start at the fixed latency");

	startGivesDone: assert property (@(posedge clk) disable iff (!arstN)
		$past(accepted, `FDIV_LATENCY + 1) |-> done)
		else $error("start was not followed by done at the fixed latency");

	idleAtDone: assert property (@(posedge clk) disable iff (!arstN) done |-> !busy)
		else $error("busy was high while done fired");

	invalidIsNaN: assert property (@(posedge clk) disable iff (!arstN)
		flags[4] |-> (result == `FDIV_QNAN))
		else $error("invalid flag came with a result other than the quiet NaN");

endmodule

bind fdivTop fdivTop_sva u_sva (
	.clk   (clk),
	.arstN (arstN),
	.start (start),
	.busy  (busy),
	.done  (done),
	.result(result),
	.flags (flags)
);

// ==== testbench/fdivTb.sv ====
// Testbench for the single-precision floating-point divider
// Reads operand pairs and expected words from the vector file, drives each
// operation with a random idle gap and checks result, flags and latency
`timescale 1ns/1ps
`include "fdiv_consts.svh"

module fdivTb;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 3;
	localparam int LATENCY      = `FDIV_LATENCY;
	localparam logic [7:0] LFSR_SEED = 8'd91;

	logic clk;
	logic arstN;
	logic start;
	fdivPkg::float_t a;
	fdivPkg::float_t b;
	fdivPkg::float_t result;
	fdivPkg::flags_t flags;
	logic done;
	logic busy;

	fdivPkg::float_t vecA[$];            // Dividends
	fdivPkg::float_t vecB[$];            // Divisors
	fdivPkg::float_t vecRes[$];          // Expected packed quotients
	fdivPkg::flags_t vecFlags[$];        // Expected status flags
	int vecCount = 0;
	logic loaded = 1'b0;                 // Lets the watchdog size its limit
	int mismatchCount = 0;
	int otherCount = 0;
	int doneCount = 0;                   // Every done strobe seen after reset
	logic [7:0] lfsr;

	fdivTop u_dut (
		.clk   (clk),
		.arstN (arstN),
		.start (start),
		.a     (a),
		.b     (b),
		.result(result),
		.flags (flags),
		.done  (done),
		.busy  (busy)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Fibonacci LFSR with taps 8, 6, 5 and 4 that shifts toward the top bit
	function automatic logic [7:0] nextLfsr(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic checkResult(input fdivPkg::float_t got, input fdivPkg::float_t want,
		input string what);
		if (got !== want) begin
			mismatchCount++;
			$display("Mismatch at %0t ns: result of %s is %h, expected %h",
				$time, what, got, want);
		end
	endtask

	task automatic checkFlags(input fdivPkg::flags_t got, input fdivPkg::flags_t want,
		input string what);
		if (got !== want) begin
			mismatchCount++;
			$display("Mismatch at %0t ns: flags of %s are %b, expected %b",
				$time, what, got, want);
		end
	endtask

	task automatic checkLatency(input int got, input int want, input string what);
		if (got != want) begin
			mismatchCount++;
			$display("Mismatch at %0t ns: done for %s came after %0d cycles, expected %0d",
				$time, what, got, want);
		end
	endtask

	task automatic checkLevel(input logic got, input logic want, input string what);
		if (got !== want) begin
			mismatchCount++;
			$display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	// Lines starting with # are comments and the rest hold four hex columns
	task automatic loadVectors();
		int fd;
		int n;
		string line;
		fdivPkg::float_t va;
		fdivPkg::float_t vb;
		fdivPkg::float_t vr;
		fdivPkg::flags_t vf;
		fd = $fopen("testbench/fdiv_vectors.txt", "r");
		if (fd == 0) begin
			otherCount++;
			$display("Error: the vector file testbench/fdiv_vectors.txt could not be opened");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %h %h %h", va, vb, vr, vf);
				if (n == 4) begin
					vecA.push_back(va);
					vecB.push_back(vb);
					vecRes.push_back(vr);
					vecFlags.push_back(vf);
				end
			end
		end
		$fclose(fd);
		vecCount = vecA.size();
		if (vecCount == 0) begin
			otherCount++;
			$display("Error: the vector file holds no vectors");
		end
	endtask

	// Counts strobes away from the edge, so one done counts once
	always @(negedge clk) begin
		if (arstN && done)
			doneCount++;
	end

	initial begin
		int i;
		int k;
		int gap;
		int cycles;
		string tag;
		arstN = 1'b0;
		start = 1'b0;
		a     = '0;
		b     = '0;
		lfsr  = LFSR_SEED;
		loadVectors();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 arstN = 1'b1;
		@(posedge clk);
		#1;
		checkLevel(done, 1'b0, "done after reset");
		checkLevel(busy, 1'b0, "busy after reset");
		checkResult(result, '0, "reset state");
		checkFlags(flags, '0, "reset state");

		for (i = 0; i < vecCount; i++) begin
			gap = 0;
			for (k = 0; k < 2; k++) begin
				lfsr = nextLfsr(lfsr);                  // One step per gap bit
				gap  = gap | (int'(lfsr[0]) << k);
			end
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			tag   = $sformatf("%h / %h", vecA[i], vecB[i]);
			a     = vecA[i];
			b     = vecB[i];
			start = 1'b1;
			@(posedge clk);                             // Start edge
			#1 start = 1'b0;
			checkLevel(busy, 1'b1, {"busy after start of ", tag});
			cycles = 0;
			while (!done && cycles < LATENCY + 5) begin
				@(posedge clk);
				#1;
				cycles++;
			end
			if (!done) begin
				otherCount++;
				$display("Error: no done strobe within %0d cycles for %s", cycles, tag);
			end else begin
				checkLatency(cycles, LATENCY, tag);
				checkLevel(busy, 1'b0, {"busy at done of ", tag});
				checkResult(result, vecRes[i], tag);
				checkFlags(flags, vecFlags[i], tag);
			end
		end

		repeat (2) begin
			@(posedge clk);
			#1;
		end
		if (doneCount != vecCount) begin
			otherCount++;
			$display("Error: saw %0d done strobes for %0d operations", doneCount, vecCount);
		end
		$display("Errors: %0d mismatches, %0d other failures over %0d vectors",
			mismatchCount, otherCount, vecCount);
		if (mismatchCount == 0 && otherCount == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Each operation needs at most LATENCY + 4 clocks including its idle gap
	initial begin
		int limit;
		wait (loaded);
		limit = vecCount * (LATENCY + 4) + 20;
		repeat (limit) @(posedge clk);
		$display("Error: watchdog expired after %0d clock periods before the run ended", limit);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== testbench/fdiv_vectors.txt ====
# Columns: dividend a, divisor b, expected result, expected flags, all hex
# Flags from the top bit: invalid, divByZero, overflow, underflow, inexact
40C00000 40400000 40000000 00
3F800000 40800000 3E800000 00
C1000000 40000000 C0800000 00
40F00000 C0200000 C0400000 00
3F400000 40400000 3E800000 00
40400000 40800000 3F400000 00
3F900000 3FC00000 3F400000 00
3F800000 40400000 3EAAAAAA 01
BF800000 40400000 BEAAAAAA 01
3F800000 C0400000 BEAAAAAA 01
BF800000 C0400000 3EAAAAAA 01
40000000 40E00000 3E924924 01
C0000000 40E00000 BE924924 01
41200000 40400000 40555555 01
3F800000 41200000 3DCCCCCC 01
40E00000 40400000 40155555 01
7FC12345 3F800000 7FC00000 10
3F800000 FF800001 7FC00000 10
00000000 80000000 7FC00000 10
7F800000 FF800000 7FC00000 10
7F800001 00000000 7FC00000 10
3F800000 00000000 7F800000 08
C0A00000 00000000 FF800000 08
40000000 80000000 FF800000 08
7F800000 40000000 7F800000 00
FF800000 40400000 FF800000 00
7F800000 00000000 7F800000 00
40400000 FF800000 80000000 00
00000000 40A00000 00000000 00
80000000 40400000 80000000 00
00000000 7F800000 00000000 00
7F000000 00800000 7F800000 05
FF000000 00800000 FF800000 05
7F000000 3F000000 7F800000 05
7F7FFFFF 3F800000 7F7FFFFF 00
00800000 7F000000 00000000 03
80800000 7F000000 80000000 03
00800000 40000000 00000000 03
00800000 3F800000 00800000 00
00400000 3F800000 00000000 00
3F800000 00000001 7F800000 08

// ==== verilog.f ====
+incdir+source
source/fdivPkg.sv
source/mantDivR8.sv
source/expSpecial.sv
source/normPack.sv
source/fdivTop.sv
testbench/fdivTop_sva.sv
testbench/fdivTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the floating-point divider testbench with Verilator and runs it.
# The run passes only when the log holds the testbench's pass line.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fdivSim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module fdivTb \
	--Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation ended with status $simStatus"
	exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
